// File: mulDivUnit.f
common/mulDivPkg.sv
arith/shiftAddMult.sv
arith/restoringDiv.sv
hw/iterCtrl.sv
hw/operandPrep.sv
hw/resultSelect.sv
hw/mulDivUnit.sv
bench/mulDivTb.sv

// File: Makefile
SRCS := $(shell cat mulDivUnit.f)

.PHONY: all run clean

all: obj_dir/VmulDivTb

obj_dir/VmulDivTb: mulDivUnit.f $(SRCS)
	verilator --binary --timing --assert --top-module mulDivTb -f mulDivUnit.f -o VmulDivTb

run: obj_dir/VmulDivTb
	./obj_dir/VmulDivTb | tee sim.log
	grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: bench/mulDivTb.sv
`timescale 1ns/100ps
`default_nettype none

module mulDivTb;

  localparam int multOps = 40;
  localparam int divOps = 40;
  localparam int specialOps = 8;
  localparam int busyOps = 8;
  localparam int numOps = multOps + divOps + specialOps + busyOps;
  localparam int clkPeriod = 4;
  localparam int resetCycles = 16;
  localparam int latency = 33;
  localparam int maxEdges = 40;

  logic              clk;
  logic              rstN;
  logic              start;
  mulDivPkg::opCodeT opCode;
  mulDivPkg::wordT   lOp;
  mulDivPkg::wordT   rOp;
  mulDivPkg::wordT   result;
  logic              busy;
  logic              done;
  logic              divByZero;
  logic              divOverflow;

  int seed;
  int passCount;
  int failCount;
  int testErrors;

  mulDivUnit i_mulDivUnit (
    .clk         (clk),
    .rstN        (rstN),
    .start       (start),
    .opCode      (opCode),
    .lOp         (lOp),
    .rOp         (rOp),
    .result      (result),
    .busy        (busy),
    .done        (done),
    .divByZero   (divByZero),
    .divOverflow (divOverflow)
  );

  always #(clkPeriod / 2) clk = ~clk;

  task automatic checkWord(input string name, input mulDivPkg::wordT expected,
                           input mulDivPkg::wordT actual);
    if (actual !== expected) begin
      $display("ERR %s expected %h actual %h", name, expected, actual);
      testErrors++;
    end
  endtask

  task automatic checkFlag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("ERR %s expected %b actual %b", name, expected, actual);
      testErrors++;
    end
  endtask

  task automatic reportProblem(input string msg);
    $display("%s", msg);
    testErrors++;
  endtask

  task automatic finishTest(input string name);
    if (testErrors == 0) begin
      passCount++;
      $display("test %s ok", name);
    end else begin
      failCount++;
      $display("test %s failed with %0d errors", name, testErrors);
    end
    testErrors = 0;
  endtask

  function automatic logic modelDivZero(input mulDivPkg::opCodeT op, input mulDivPkg::wordT l);
    return op[2] && (l == '0);
  endfunction

  function automatic logic modelDivOvf(input mulDivPkg::opCodeT op, input mulDivPkg::wordT l,
                                       input mulDivPkg::wordT r);
    return (op == mulDivPkg::opDiv || op == mulDivPkg::opRem) &&
           (r == mulDivPkg::minNeg) && (l == '1);
  endfunction

  // architectural M-extension result with rOp as the dividend
  function automatic mulDivPkg::wordT modelResult(input mulDivPkg::opCodeT op,
                                                  input mulDivPkg::wordT l,
                                                  input mulDivPkg::wordT r);
    mulDivPkg::dwordT lx;
    mulDivPkg::dwordT rx;
    mulDivPkg::dwordT prod;
    int               sl;
    int               sr;
    lx = {{32{l[31]}}, l};
    rx = {{32{r[31]}}, r};
    sl = l;
    sr = r;
    case (op)
      mulDivPkg::opMul: begin
        prod = lx * rx;
        return prod[31:0];
      end
      mulDivPkg::opMulh: begin
        prod = lx * rx;
        return prod[63:32];
      end
      mulDivPkg::opMulhsu: begin
        prod = lx * {32'b0, r};
        return prod[63:32];
      end
      mulDivPkg::opMulhu: begin
        prod = {32'b0, l} * {32'b0, r};
        return prod[63:32];
      end
      mulDivPkg::opDiv: begin
        if (l == '0) return '1;
        if (modelDivOvf(op, l, r)) return mulDivPkg::minNeg;
        return sr / sl;
      end
      mulDivPkg::opDivu: return (l == '0) ? '1 : r / l;
      mulDivPkg::opRem: begin
        if (l == '0) return r;
        if (modelDivOvf(op, l, r)) return '0;
        return sr % sl;
      end
      default: return (l == '0) ? r : r % l;
    endcase
  endfunction

  // corner values mixed into the random operands
  function automatic mulDivPkg::wordT randOperand();
    int pick;
    pick = $random(seed) & 7;
    case (pick)
      0: return mulDivPkg::minNeg;
      1: return '1;
      2: return $random(seed) % 8;
      3: return {$random(seed)} % 15 + 1;
      default: return $random(seed);
    endcase
  endfunction

  task automatic runOp(input string name, input mulDivPkg::opCodeT op,
                       input mulDivPkg::wordT l, input mulDivPkg::wordT r, input bit pokeBusy);
    mulDivPkg::wordT expResult;
    int              edges;
    int              busyLow;
    int              pick;
    expResult = modelResult(op, l, r);
    edges = 0;
    busyLow = 0;
    @(negedge clk);
    start = 1'b1;
    opCode = op;
    lOp = l;
    rOp = r;
    @(negedge clk);
    start = 1'b0;
    // operands only matter on the start edge
    lOp = $random(seed);
    rOp = $random(seed);
    while (!done && edges < maxEdges) begin
      if (!busy) busyLow++;
      if (pokeBusy && edges == 10) begin
        pick = $random(seed);
        start = 1'b1;
        opCode = mulDivPkg::opCodeT'(pick[2:0]);
      end else begin
        start = 1'b0;
      end
      @(negedge clk);
      edges++;
    end
    start = 1'b0;
    if (!done) begin
      reportProblem($sformatf("%s: done did not arrive within %0d edges", name, maxEdges));
    end else if (edges != latency) begin
      reportProblem($sformatf("%s: done came %0d edges after start, not %0d",
                              name, edges, latency));
    end
    if (busyLow != 0) reportProblem($sformatf("%s: busy was low before done", name));
    if (busy) reportProblem($sformatf("%s: busy still high with done", name));
    checkWord(name, expResult, result);
    checkFlag({name, " divByZero"}, modelDivZero(op, l), divByZero);
    checkFlag({name, " divOverflow"}, modelDivOvf(op, l, r), divOverflow);
    finishTest(name);
  endtask

  initial begin
    #((numOps * 40 * clkPeriod + resetCycles * clkPeriod) * 2);
    $display("timeout: the operations did not complete in the expected time");
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    mulDivPkg::opCodeT op;
    mulDivPkg::wordT   l;
    clk = 1'b0;
    rstN = 1'b0;
    start = 1'b0;
    opCode = mulDivPkg::opMul;
    lOp = '0;
    rOp = '0;
    seed = 75;
    passCount = 0;
    failCount = 0;
    testErrors = 0;
    repeat (resetCycles) @(negedge clk);
    rstN = 1'b1;
    checkFlag("reset busy", 1'b0, busy);
    checkFlag("reset done", 1'b0, done);
    checkWord("reset result", '0, result);
    checkFlag("reset divByZero", 1'b0, divByZero);
    checkFlag("reset divOverflow", 1'b0, divOverflow);
    finishTest("reset");
    for (int i = 0; i < multOps; i++) begin
      op = mulDivPkg::opCodeT'(i % 4);
      runOp($sformatf("%s #%0d", op.name(), i), op, randOperand(), randOperand(), 1'b0);
    end
    for (int i = 0; i < divOps; i++) begin
      op = mulDivPkg::opCodeT'(4 + i % 4);
      l = randOperand();
      if (l == '0) l = 1;
      runOp($sformatf("%s #%0d", op.name(), i), op, l, randOperand(), 1'b0);
    end
    // zero divisor then signed overflow
    for (int i = 4; i < 8; i++) begin
      op = mulDivPkg::opCodeT'(i);
      runOp($sformatf("%s by zero", op.name()), op, '0, randOperand(), 1'b0);
    end
    runOp("opDiv overflow", mulDivPkg::opDiv, '1, mulDivPkg::minNeg, 1'b0);
    runOp("opRem overflow", mulDivPkg::opRem, '1, mulDivPkg::minNeg, 1'b0);
    // multiplies on the divide corner operands keep both flags clear
    runOp("opMulh zero lOp", mulDivPkg::opMulh, '0, randOperand(), 1'b0);
    runOp("opMul overflow operands", mulDivPkg::opMul, '1, mulDivPkg::minNeg, 1'b0);
    for (int i = 0; i < busyOps; i++) begin
      op = mulDivPkg::opCodeT'(i);
      runOp($sformatf("%s start while busy", op.name()), op, randOperand(), randOperand(), 1'b1);
    end
    $display("counts: %0d passed, %0d failed", passCount, failCount);
    if (failCount == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: hw/mulDivUnit.sv
`timescale 1ns/100ps
`default_nettype none

module mulDivUnit (
  input  wire logic               clk,
  input  wire logic               rstN,
  input  wire logic               start,
  input  mulDivPkg::opCodeT       opCode,
  input  mulDivPkg::wordT         lOp,
  input  mulDivPkg::wordT         rOp,
  output mulDivPkg::wordT         result,
  output logic                    busy,
  output logic                    done,
  output logic                    divByZero,
  output logic                    divOverflow
);

  logic loadEn;
  logic stepEn;
  logic finishEn;

  mulDivPkg::wordT   magL;
  mulDivPkg::wordT   magR;
  mulDivPkg::opCodeT opReg;
  logic              negLow;
  logic              negHigh;
  logic              divZero;
  logic              divOvf;

  mulDivPkg::dwordT  product;
  mulDivPkg::wordT   quotient;
  mulDivPkg::wordT   remainder;

  iterCtrl i_iterCtrl (
    .clk      (clk),
    .rstN     (rstN),
    .start    (start),
    .loadEn   (loadEn),
    .stepEn   (stepEn),
    .finishEn (finishEn),
    .busy     (busy),
    .done     (done)
  );

  operandPrep i_operandPrep (
    .clk     (clk),
    .rstN    (rstN),
    .loadEn  (loadEn),
    .opCode  (opCode),
    .lOp     (lOp),
    .rOp     (rOp),
    .magL    (magL),
    .magR    (magR),
    .opReg   (opReg),
    .negLow  (negLow),
    .negHigh (negHigh),
    .divZero (divZero),
    .divOvf  (divOvf)
  );

  shiftAddMult i_shiftAddMult (
    .clk          (clk),
    .rstN         (rstN),
    .loadEn       (loadEn),
    .stepEn       (stepEn),
    .multiplicand (magL),
    .multiplier   (magR),
    .product      (product)
  );

  // rOp is the dividend, lOp the divisor
  restoringDiv i_restoringDiv (
    .clk       (clk),
    .rstN      (rstN),
    .loadEn    (loadEn),
    .stepEn    (stepEn),
    .dividend  (magR),
    .divisor   (magL),
    .quotient  (quotient),
    .remainder (remainder)
  );

  resultSelect i_resultSelect (
    .clk         (clk),
    .rstN        (rstN),
    .finishEn    (finishEn),
    .opReg       (opReg),
    .negLow      (negLow),
    .negHigh     (negHigh),
    .divZero     (divZero),
    .divOvf      (divOvf),
    .product     (product),
    .quotient    (quotient),
    .remainder   (remainder),
    .result      (result),
    .divByZero   (divByZero),
    .divOverflow (divOverflow)
  );

endmodule

`default_nettype wire

// File: hw/resultSelect.sv
`timescale 1ns/100ps
`default_nettype none

module resultSelect (
  input  wire logic               clk,
  input  wire logic               rstN,
  input  wire logic               finishEn,
  input  mulDivPkg::opCodeT       opReg,
  input  wire logic               negLow,
  input  wire logic               negHigh,
  input  wire logic               divZero,
  input  wire logic               divOvf,
  input  mulDivPkg::dwordT        product,
  input  mulDivPkg::wordT         quotient,
  input  mulDivPkg::wordT         remainder,
  output mulDivPkg::wordT         result,
  output logic                    divByZero,
  output logic                    divOverflow
);

  localparam int w = mulDivPkg::dataW;

  mulDivPkg::dwordT prodSigned;
  mulDivPkg::wordT  quoSigned;
  mulDivPkg::wordT  remSigned;
  mulDivPkg::wordT  nextResult;

  assign prodSigned = negHigh ? -product : product;
  assign quoSigned  = negLow ? -quotient : quotient;
  // also rebuilds the dividend when the divisor was zero
  assign remSigned  = negHigh ? -remainder : remainder;

  always_comb begin
    unique case (opReg)
      mulDivPkg::opMul: nextResult = prodSigned[w-1:0];
      mulDivPkg::opMulh, mulDivPkg::opMulhsu, mulDivPkg::opMulhu: begin
        nextResult = prodSigned[2*w-1:w];
      end
      mulDivPkg::opDiv, mulDivPkg::opDivu: nextResult = quoSigned;
      default: nextResult = remSigned;
    endcase
    // bit 1 of a divide opcode picks the remainder
    if (divZero) begin
      nextResult = opReg[1] ? remSigned : '1;
    end else if (divOvf) begin
      nextResult = opReg[1] ? '0 : mulDivPkg::minNeg;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      result      <= '0;
      divByZero   <= 1'b0;
      divOverflow <= 1'b0;
    end else if (finishEn) begin
      result      <= nextResult;
      divByZero   <= divZero;
      divOverflow <= divOvf;
    end
  end

endmodule

`default_nettype wire

// File: hw/operandPrep.sv
`timescale 1ns/100ps
`default_nettype none

module operandPrep (
  input  wire logic               clk,
  input  wire logic               rstN,
  input  wire logic               loadEn,
  input  mulDivPkg::opCodeT       opCode,
  input  mulDivPkg::wordT         lOp,
  input  mulDivPkg::wordT         rOp,
  output mulDivPkg::wordT         magL,
  output mulDivPkg::wordT         magR,
  output mulDivPkg::opCodeT       opReg,
  output logic                    negLow,
  output logic                    negHigh,
  output logic                    divZero,
  output logic                    divOvf
);

  logic signedL;
  logic signedR;
  logic negL;
  logic negR;
  logic isDiv;

  always_comb begin
    unique case (opCode)
      mulDivPkg::opMul, mulDivPkg::opMulh, mulDivPkg::opDiv, mulDivPkg::opRem: begin
        signedL = 1'b1;
        signedR = 1'b1;
      end
      mulDivPkg::opMulhsu: begin
        signedL = 1'b1;
        signedR = 1'b0;
      end
      default: begin
        signedL = 1'b0;
        signedR = 1'b0;
      end
    endcase
  end

  assign negL  = signedL & lOp[mulDivPkg::dataW-1];
  assign negR  = signedR & rOp[mulDivPkg::dataW-1];
  assign isDiv = opCode[2];

  // magnitudes go straight to the cores on the start edge
  assign magL = negL ? -lOp : lOp;
  assign magR = negR ? -rOp : rOp;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      opReg   <= mulDivPkg::opMul;
      negLow  <= 1'b0;
      negHigh <= 1'b0;
      divZero <= 1'b0;
      divOvf  <= 1'b0;
    end else if (loadEn) begin
      opReg   <= opCode;
      // quotient sign for divides only
      negLow  <= isDiv & (negL ^ negR);
      // product sign, or remainder follows the dividend
      negHigh <= isDiv ? negR : (negL ^ negR);
      divZero <= isDiv && (lOp == '0);
      divOvf  <= (opCode == mulDivPkg::opDiv || opCode == mulDivPkg::opRem) &&
                 (rOp == mulDivPkg::minNeg) && (lOp == '1);
    end
  end

  // a zero divisor can never also be all ones
  assert property (@(posedge clk) disable iff (!rstN) !(divZero && divOvf));

endmodule

`default_nettype wire

// File: hw/iterCtrl.sv
`timescale 1ns/100ps
`default_nettype none

module iterCtrl (
  input  wire logic clk,
  input  wire logic rstN,
  input  wire logic start,
  output logic      loadEn,
  output logic      stepEn,
  output logic      finishEn,
  output logic      busy,
  output logic      done
);

  mulDivPkg::ctrlStateT state;
  mulDivPkg::cntT       cnt;

  // start is dropped while an operation runs
  assign loadEn   = start && (state == mulDivPkg::stIdle);
  assign stepEn   = (state == mulDivPkg::stIter);
  assign finishEn = (state == mulDivPkg::stFinish);
  assign busy     = (state != mulDivPkg::stIdle);

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state <= mulDivPkg::stIdle;
      cnt   <= '0;
      done  <= 1'b0;
    end else begin
      done <= finishEn;
      unique case (state)
        mulDivPkg::stIdle: begin
          if (start) begin
            state <= mulDivPkg::stIter;
            cnt   <= mulDivPkg::cntT'(mulDivPkg::iterCount - 1);
          end
        end
        mulDivPkg::stIter: begin
          // last step when the count has run out
          if (cnt == '0) begin
            state <= mulDivPkg::stFinish;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        mulDivPkg::stFinish: begin
          state <= mulDivPkg::stIdle;
        end
        default: begin
          state <= mulDivPkg::stIdle;
        end
      endcase
    end
  end

  // done is a single-cycle pulse
  assert property (@(posedge clk) disable iff (!rstN) done |=> !done);

  // no load while the cores are stepping
  assert property (@(posedge clk) disable iff (!rstN) !(stepEn && loadEn));

endmodule

`default_nettype wire

// File: arith/restoringDiv.sv
`timescale 1ns/100ps
`default_nettype none

module restoringDiv (
  input  wire logic       clk,
  input  wire logic       rstN,
  input  wire logic       loadEn,
  input  wire logic       stepEn,
  input  mulDivPkg::wordT dividend,
  input  mulDivPkg::wordT divisor,
  output mulDivPkg::wordT quotient,
  output mulDivPkg::wordT remainder
);

  localparam int w = mulDivPkg::dataW;

  mulDivPkg::wordT divReg;
  mulDivPkg::wordT quoReg;
  mulDivPkg::wordT remReg;
  logic [w+1:0]    trial;
  logic            borrow;

  always_ff @(posedge clk) begin
    if (loadEn) begin
      divReg <= divisor;
    end
  end

  // shifted remainder minus divisor, top bit is the borrow
  assign trial  = {1'b0, remReg, quoReg[w-1]} - {2'b00, divReg};
  assign borrow = trial[w+1];

  always_ff @(posedge clk) begin
    if (!rstN) begin
      quoReg <= '0;
      remReg <= '0;
    end else if (loadEn) begin
      quoReg <= dividend;
      remReg <= '0;
    end else if (stepEn) begin
      if (borrow) begin
        // restore, keep the shifted value
        remReg <= {remReg[w-2:0], quoReg[w-1]};
        quoReg <= {quoReg[w-2:0], 1'b0};
      end else begin
        remReg <= trial[w-1:0];
        quoReg <= {quoReg[w-2:0], 1'b1};
      end
    end
  end

  // zero divisor ends with all ones and the dividend here
  assign quotient  = quoReg;
  assign remainder = remReg;

endmodule

`default_nettype wire

// File: arith/shiftAddMult.sv
`timescale 1ns/100ps
`default_nettype none

module shiftAddMult (
  input  wire logic        clk,
  input  wire logic        rstN,
  input  wire logic        loadEn,
  input  wire logic        stepEn,
  input  mulDivPkg::wordT  multiplicand,
  input  mulDivPkg::wordT  multiplier,
  output mulDivPkg::dwordT product
);

  localparam int w = mulDivPkg::dataW;

  mulDivPkg::wordT  mcandReg;
  mulDivPkg::dwordT prodReg;
  mulDivPkg::wordT  addend;
  logic [w:0]       partial;

  // multiplicand only matters while stepping
  always_ff @(posedge clk) begin
    if (loadEn) begin
      mcandReg <= multiplicand;
    end
  end

  assign addend  = prodReg[0] ? mcandReg : '0;
  // one extra bit keeps the carry of the add
  assign partial = {1'b0, prodReg[2*w-1:w]} + {1'b0, addend};

  always_ff @(posedge clk) begin
    if (!rstN) begin
      prodReg <= '0;
    end else if (loadEn) begin
      prodReg <= {{w{1'b0}}, multiplier};
    end else if (stepEn) begin
      // add then shift right, carry enters the top
      prodReg <= {partial, prodReg[w-1:1]};
    end
  end

  assign product = prodReg;

endmodule

`default_nettype wire

// File: common/mulDivPkg.sv
`default_nettype none

package mulDivPkg;

  // datapath widths
  localparam int dataW = 32;

  typedef logic [dataW-1:0]   wordT;
  typedef logic [2*dataW-1:0] dwordT;

  // one arithmetic step per bit of the operand
  localparam int iterCount = 32;
  localparam int cntW = 6;

  typedef logic [cntW-1:0] cntT;

  // bit 2 set means division
  typedef enum logic [2:0] {
    opMul    = 3'd0,
    opMulh   = 3'd1,
    opMulhsu = 3'd2,
    opMulhu  = 3'd3,
    opDiv    = 3'd4,
    opDivu   = 3'd5,
    opRem    = 3'd6,
    opRemu   = 3'd7
  } opCodeT;

  typedef enum logic [1:0] {
    stIdle   = 2'd0,
    stIter   = 2'd1,
    stFinish = 2'd2
  } ctrlStateT;

  // most negative two's complement word
  localparam wordT minNeg = {1'b1, {(dataW-1){1'b0}}};

endpackage

`default_nettype wire
